// ==== logic/ttl_reg_pkg.sv ====
package ttl_reg_pkg;

   //////////////////////////////
   // Address map
   //////////////////////////////

   localparam int ADDR_W = 4;                  // Wishbone word address width
   localparam int IDX_W  = 2;                  // Data register index, up to 4 regs

   // Data registers sit at 0 .. NUM_REGS-1
   localparam logic [ADDR_W-1:0] ADDR_FLAG    = 4'd4;  // Flags 0-3
   localparam logic [ADDR_W-1:0] ADDR_OE      = 4'd5;  // Active-low enables
   localparam logic [ADDR_W-1:0] ADDR_FLAG_HI = 4'd6;  // Flags 4-7

   //////////////////////////////
   // Reset values
   //////////////////////////////

   // Every byte starts with /OE high, so the ports come up dark
   localparam logic [3:0] OE_RESET = 4'b1111;

   //////////////////////////////
   // Access target
   //////////////////////////////

   typedef enum logic [1:0] {
      SEL_NONE,                                // Unmapped, reads zero
      SEL_DATA,                                // 74x273 data byte
      SEL_FLAG,                                // 74x112 flag half
      SEL_OE                                   // Enable register
   } sel_e;

   //////////////////////////////
   // Write word
   //////////////////////////////

   // One J-K command for four flags
   typedef struct packed {
      logic [3:0] j;                           // Upper nibble
      logic [3:0] k;                           // Lower nibble
   } jk_cmd_t;

   // Same bus byte, read as data or as J/K masks
   typedef union packed {
      logic [7:0] byte_val;
      jk_cmd_t    jk;
   } wr_word_u;

endpackage

// ==== logic/reg_bus_if.sv ====
`timescale 1ns/1ps

interface reg_bus_if #(
   parameter int NUM_REGS = 4
);
   import ttl_reg_pkg::*;

   // Command from the front end, valid while wr is high
   logic             wr;          // One-cycle write strobe
   sel_e             sel;         // Decoded target
   logic [IDX_W-1:0] index;       // Data register number
   logic             hi;          // Upper flag half
   wr_word_u         wdata;

   // Read side
   logic [7:0]          reg_rdata;     // Indexed data byte
   logic [NUM_REGS-1:0] oe_rdata;      // Raw /OE bits
   logic [7:0]          flag_rdata;    // Addressed flag half, zero-extended

   modport front (
      output wr, sel, index, hi, wdata,
      input  reg_rdata, oe_rdata, flag_rdata
   );

   modport flags (
      input  wr, sel, hi, wdata,
      output flag_rdata
   );

   modport regs (
      input  wr, sel, index, wdata,
      output reg_rdata, oe_rdata
   );

endinterface

// ==== logic/wb_reg_front.sv ====
`timescale 1ns/1ps

module wb_reg_front #(
   parameter int NUM_REGS = 4
) (
   input  logic                           clk,
   input  logic                           rst,
   input  logic                           wb_cyc,
   input  logic                           wb_stb,
   input  logic                           wb_we,
   input  logic [ttl_reg_pkg::ADDR_W-1:0] wb_adr,
   input  logic [7:0]                     wb_dat_i,
   output logic [7:0]                     wb_dat_o,
   output logic                           wb_ack,
   reg_bus_if.front                       bus
);
   import ttl_reg_pkg::*;

   logic       access;     // Cycle that will be acked on the next edge
   logic [7:0] oe_byte;    // Enable bits padded to a byte
   logic [7:0] rd_byte;

   // No ack pending means this is the first cycle of the access
   assign access = wb_cyc & wb_stb & ~wb_ack;

   //////////////////////////////
   // Address decode
   //////////////////////////////

   always_comb begin
      bus.sel   = SEL_NONE;
      bus.index = wb_adr[IDX_W-1:0];
      bus.hi    = 1'b0;
      if (wb_adr < ADDR_W'(NUM_REGS)) begin
         bus.sel = SEL_DATA;                      // Only populated registers
      end else if (wb_adr == ADDR_FLAG) begin
         bus.sel = SEL_FLAG;
      end else if (wb_adr == ADDR_FLAG_HI) begin
         bus.sel = SEL_FLAG;
         bus.hi  = 1'b1;                          // Flags 4-7
      end else if (wb_adr == ADDR_OE) begin
         bus.sel = SEL_OE;
      end
   end

   // Banks load on the same edge that raises ack
   assign bus.wr    = access & wb_we;
   assign bus.wdata = wr_word_u'(wb_dat_i);

   //////////////////////////////
   // Read mux
   //////////////////////////////

   always_comb begin
      oe_byte               = '0;
      oe_byte[NUM_REGS-1:0] = bus.oe_rdata;
   end

   always_comb begin
      case (bus.sel)
         SEL_DATA: rd_byte = bus.reg_rdata;
         SEL_FLAG: rd_byte = bus.flag_rdata;
         SEL_OE:   rd_byte = oe_byte;
         default:  rd_byte = 8'h00;               // Holes read zero
      endcase
   end

   //////////////////////////////
   // Ack and read data
   //////////////////////////////

   always_ff @(posedge clk) begin
      if (!rst) begin
         wb_ack <= 1'b0;
      end else begin
         wb_ack <= access;                        // Single-cycle pulse
      end
   end

   // Captured with the ack so the master sees it alongside
   always_ff @(posedge clk) begin
      if (access) wb_dat_o <= rd_byte;
   end

endmodule

// ==== logic/jk_flag_bank.sv ====
`timescale 1ns/1ps

module jk_flag_bank (
   input  logic       clk,
   input  logic       rst,
   reg_bus_if.flags   bus,
   output logic [7:0] flag_q
);
   import ttl_reg_pkg::*;

   logic [3:0] cur;       // Addressed half as it stands
   logic [3:0] nxt;       // Half after the J-K command
   logic       flag_wr;

   assign flag_wr = bus.wr & (bus.sel == SEL_FLAG);

   // Pick the four flags the command goes to
   assign cur = bus.hi ? flag_q[7:4] : flag_q[3:0];

   //////////////////////////////
   // 74x112 next state
   //////////////////////////////

   // Q+ = J./Q + /K.Q per bit
   //  J K
   //  0 0  hold
   //  0 1  clear
   //  1 0  set
   //  1 1  toggle
   assign nxt = (bus.wdata.jk.j & ~cur) | (~bus.wdata.jk.k & cur);

   always_ff @(posedge clk) begin
      if (!rst) begin
         flag_q <= '0;
      end else if (flag_wr) begin
         if (bus.hi) begin
            flag_q[7:4] <= nxt;                   // Low half untouched
         end else begin
            flag_q[3:0] <= nxt;                   // High half untouched
         end
      end
   end

   // Readback of the addressed half only
   assign bus.flag_rdata = {4'b0000, cur};

endmodule

// ==== logic/octal_reg_bank.sv ====
`timescale 1ns/1ps

module octal_reg_bank #(
   parameter int NUM_REGS = 4
) (
   input  logic                     clk,
   input  logic                     rst,
   reg_bus_if.regs                  bus,
   output logic [NUM_REGS-1:0][7:0] reg_q,
   output logic [NUM_REGS-1:0]      oe_n
);
   import ttl_reg_pkg::*;

   logic data_wr;
   logic oe_wr;
   logic idx_ok;          // Index names a populated register

   assign data_wr = bus.wr & (bus.sel == SEL_DATA);
   assign oe_wr   = bus.wr & (bus.sel == SEL_OE);
   assign idx_ok  = (int'(bus.index) < NUM_REGS);

   //////////////////////////////
   // 74x273 data bytes
   //////////////////////////////

   always_ff @(posedge clk) begin
      if (!rst) begin
         reg_q <= '0;                             // /CLR clears every byte
      end else if (data_wr && idx_ok) begin
         reg_q[bus.index] <= bus.wdata.byte_val;
      end
   end

   //////////////////////////////
   // Output enables
   //////////////////////////////

   // One /OE bit per byte from the low bits of the written word
   always_ff @(posedge clk) begin
      if (!rst) begin
         oe_n <= OE_RESET[NUM_REGS-1:0];
      end else if (oe_wr) begin
         oe_n <= bus.wdata.byte_val[NUM_REGS-1:0];
      end
   end

   //////////////////////////////
   // Read data
   //////////////////////////////

   always_comb begin
      bus.reg_rdata = 8'h00;
      if (idx_ok) bus.reg_rdata = reg_q[bus.index];   // Guard short banks
   end

   assign bus.oe_rdata = oe_n;

endmodule

// ==== logic/port_driver.sv ====
`timescale 1ns/1ps

module port_driver #(
   parameter int NUM_REGS   = 4,
   parameter bit INVERT_OUT = 1'b0
) (
   input  logic                     clk,
   input  logic                     rst,
   input  logic [NUM_REGS-1:0][7:0] reg_q,
   input  logic [NUM_REGS-1:0]      oe_n,
   output logic [NUM_REGS-1:0][7:0] port_q,
   output logic [NUM_REGS-1:0]      port_en
);

   logic [NUM_REGS-1:0][7:0] drive;     // Next value of each output byte

   //////////////////////////////
   // 74x574 / 74x564 stage
   //////////////////////////////

   always_comb begin
      for (int i = 0; i < NUM_REGS; i++) begin
         drive[i] = INVERT_OUT ? ~reg_q[i] : reg_q[i];   // 564 inverts
         // Gate after the inverter so a dark byte is always zero
         if (oe_n[i]) drive[i] = 8'h00;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst) begin
         port_q  <= '0;
         port_en <= '0;                           // All bytes released
      end else begin
         port_q  <= drive;
         port_en <= ~oe_n;                        // Stands in for the tri-state
      end
   end

endmodule

// ==== logic/ttl_reg_top.sv ====
`timescale 1ns/1ps

module ttl_reg_top #(
   parameter int NUM_REGS   = 4,
   parameter bit INVERT_OUT = 1'b0
) (
   input  logic                           clk,
   input  logic                           rst,
   // Wishbone classic slave
   input  logic                           wb_cyc,
   input  logic                           wb_stb,
   input  logic                           wb_we,
   input  logic [ttl_reg_pkg::ADDR_W-1:0] wb_adr,
   input  logic [7:0]                     wb_dat_i,
   output logic [7:0]                     wb_dat_o,
   output logic                           wb_ack,
   // Card outputs
   output logic [NUM_REGS-1:0][7:0]       port_q,
   output logic [NUM_REGS-1:0]            port_en,
   output logic [7:0]                     flags_out
);

   logic [NUM_REGS-1:0][7:0] reg_q;     // Bank contents to the output stage
   logic [NUM_REGS-1:0]      oe_n;

   reg_bus_if #(.NUM_REGS(NUM_REGS)) bus_if ();

   //////////////////////////////
   // Bus side
   //////////////////////////////

   wb_reg_front #(.NUM_REGS(NUM_REGS)) u_front (
      .clk      (clk),
      .rst      (rst),
      .wb_cyc   (wb_cyc),
      .wb_stb   (wb_stb),
      .wb_we    (wb_we),
      .wb_adr   (wb_adr),
      .wb_dat_i (wb_dat_i),
      .wb_dat_o (wb_dat_o),
      .wb_ack   (wb_ack),
      .bus      (bus_if.front)
   );

   //////////////////////////////
   // Register banks
   //////////////////////////////

   jk_flag_bank u_flags (
      .clk    (clk),
      .rst    (rst),
      .bus    (bus_if.flags),
      .flag_q (flags_out)                         // Straight to the pins
   );

   octal_reg_bank #(.NUM_REGS(NUM_REGS)) u_regs (
      .clk   (clk),
      .rst   (rst),
      .bus   (bus_if.regs),
      .reg_q (reg_q),
      .oe_n  (oe_n)
   );

   // Output stage adds one cycle after the ack
   port_driver #(
      .NUM_REGS   (NUM_REGS),
      .INVERT_OUT (INVERT_OUT)
   ) u_port (
      .clk     (clk),
      .rst     (rst),
      .reg_q   (reg_q),
      .oe_n    (oe_n),
      .port_q  (port_q),
      .port_en (port_en)
   );

endmodule

// ==== verif/ttl_reg_props.sv ====
`timescale 1ns/1ps

module ttl_reg_props (
   input logic clk,
   input logic rst,
   input logic wb_cyc,
   input logic wb_stb,
   input logic wb_ack
);

   //////////////////////////////
   // Handshake rules
   //////////////////////////////

   // Ack is a single-cycle pulse
   ack_one_cycle: assert property (@(posedge clk) disable iff (!rst)
      wb_ack |=> !wb_ack)
      else $error("ack held high for two cycles");

   // Rising ack needs a request on the edge before
   ack_after_req: assert property (@(posedge clk) disable iff (!rst)
      $rose(wb_ack) |-> $past(wb_cyc && wb_stb))
      else $error("ack rose without cyc and stb");

   ack_low_in_reset: assert property (@(posedge clk)
      !rst |=> !wb_ack)                       // Cleared by the reset edge
      else $error("ack high during reset");

endmodule

bind wb_reg_front ttl_reg_props props_i (
   .clk    (clk),
   .rst    (rst),
   .wb_cyc (wb_cyc),
   .wb_stb (wb_stb),
   .wb_ack (wb_ack)
);

// ==== verif/ttl_reg_tb.sv ====
`timescale 1ns/1ps

module ttl_reg_tb;
   import ttl_reg_pkg::*;

   localparam int NUM_REGS  = 4;
   localparam int ACK_LIMIT = 16;             // Cycles allowed per access

   // Flag commands on both halves
   localparam logic [0:7][3:0] JK_ADR = {4'd4, 4'd4, 4'd4, 4'd6, 4'd6, 4'd4, 4'd6, 4'd6};
   localparam logic [0:7][7:0] JK_DAT = {8'hF0, 8'h0A, 8'h33, 8'hC0, 8'hFF, 8'h00, 8'h5A, 8'hF5};

   typedef struct {
      bit         we;
      logic [3:0] adr;
      logic [7:0] dat;
      logic [7:0] exp_rd;                     // Unused on writes
      logic [7:0] exp_flags;                  // flags_out after the step
   } step_t;

   logic                     clk;
   logic                     rst;
   logic                     wb_cyc;
   logic                     wb_stb;
   logic                     wb_we;
   logic [ADDR_W-1:0]        wb_adr;
   logic [7:0]               wb_dat_i;
   logic [7:0]               wb_dat_o;
   logic                     wb_ack;
   logic [NUM_REGS-1:0][7:0] port_q;
   logic [NUM_REGS-1:0]      port_en;
   logic [7:0]               flags_out;

   step_t               steps[$];             // Pending table entries
   integer              seed;
   logic [7:0]          reg_model [NUM_REGS];
   logic [NUM_REGS-1:0] oe_model;             // Active low like the card
   logic [7:0]          flag_model;

   ttl_reg_top dut (
      .clk       (clk),
      .rst       (rst),
      .wb_cyc    (wb_cyc),
      .wb_stb    (wb_stb),
      .wb_we     (wb_we),
      .wb_adr    (wb_adr),
      .wb_dat_i  (wb_dat_i),
      .wb_dat_o  (wb_dat_o),
      .wb_ack    (wb_ack),
      .port_q    (port_q),
      .port_en   (port_en),
      .flags_out (flags_out)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;                  // 4 ns period
   end

   //////////////////////////////
   // Checks and bus tasks
   //////////////////////////////

   task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         $display("Fail at time %0t: %s = %0h, expected %0h", $time, name, got, exp);
         $display("** FAIL **");
         $fatal(1, "value mismatch");
      end
   endtask

   task automatic wait_ack();
      int n;
      n = 0;
      do begin
         @(posedge clk);
         #1;
         n++;
      end while (!wb_ack && n < ACK_LIMIT);
      if (!wb_ack) begin
         $display("The slave never raised ack within %0d cycles", ACK_LIMIT);
         $display("** FAIL **");
         $fatal(1, "bus timeout");
      end
   endtask

   task automatic wb_write(input logic [3:0] adr, input logic [7:0] dat);
      wb_cyc   = 1'b1;
      wb_stb   = 1'b1;
      wb_we    = 1'b1;
      wb_adr   = adr;
      wb_dat_i = dat;
      wait_ack();                             // Returns just past the ack edge
      wb_cyc   = 1'b0;
      wb_stb   = 1'b0;
      wb_we    = 1'b0;
   endtask

   task automatic wb_read(input logic [3:0] adr, output logic [7:0] dat);
      wb_cyc = 1'b1;
      wb_stb = 1'b1;
      wb_we  = 1'b0;
      wb_adr = adr;
      wait_ack();
      dat    = wb_dat_o;                      // Valid with the ack
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
   endtask

   //////////////////////////////
   // Reference model
   //////////////////////////////

   // 74x112 truth table, one bit at a time
   function automatic logic [3:0] jk_next(input logic [3:0] cur, input logic [7:0] cmd);
      logic [3:0] q;
      for (int b = 0; b < 4; b++) begin
         case ({cmd[4+b], cmd[b]})
            2'b00:   q[b] = cur[b];           // Hold
            2'b01:   q[b] = 1'b0;
            2'b10:   q[b] = 1'b1;
            default: q[b] = ~cur[b];          // Toggle
         endcase
      end
      return q;
   endfunction

   function automatic logic [7:0] expect_read(input logic [3:0] adr);
      if (adr < NUM_REGS) return reg_model[adr];
      if (adr == 4'd4) return {4'h0, flag_model[3:0]};
      if (adr == 4'd6) return {4'h0, flag_model[7:4]};
      if (adr == 4'd5) return 8'(oe_model);   // Zero-extended enables
      return 8'h00;                           // Holes
   endfunction

   task automatic model_write(input logic [3:0] adr, input logic [7:0] dat);
      if (adr < NUM_REGS) reg_model[adr] = dat;
      else if (adr == 4'd4) flag_model[3:0] = jk_next(flag_model[3:0], dat);
      else if (adr == 4'd6) flag_model[7:4] = jk_next(flag_model[7:4], dat);
      else if (adr == 4'd5) oe_model = dat[NUM_REGS-1:0];
   endtask

   task automatic add_write(input logic [3:0] adr, input logic [7:0] dat);
      model_write(adr, dat);
      steps.push_back('{1'b1, adr, dat, 8'h00, flag_model});
   endtask

   task automatic add_read(input logic [3:0] adr);
      steps.push_back('{1'b0, adr, 8'h00, expect_read(adr), flag_model});
   endtask

   // Apply and drain the table
   task automatic run_steps();
      step_t      s;
      logic [7:0] rd;
      while (steps.size() > 0) begin
         s = steps.pop_front();
         if (s.we) begin
            wb_write(s.adr, s.dat);
         end else begin
            wb_read(s.adr, rd);
            check_val($sformatf("wb_dat_o[adr %0d]", s.adr), rd, s.exp_rd);
         end
         check_val("flags_out", flags_out, s.exp_flags);   // Updates at the ack edge
      end
   endtask

   task automatic check_port();
      logic [NUM_REGS-1:0][7:0] exp_q;
      logic [NUM_REGS-1:0]      exp_en;
      for (int i = 0; i < NUM_REGS; i++) begin
         exp_q[i] = oe_model[i] ? 8'h00 : reg_model[i];    // Dark bytes read zero
      end
      exp_en = ~oe_model;
      check_val("port_q", port_q, exp_q);
      check_val("port_en", port_en, exp_en);
   endtask

   //////////////////////////////
   // Sequence
   //////////////////////////////

   initial begin
      seed       = 32'h580a;
      rst        = 1'b0;
      wb_cyc     = 1'b0;
      wb_stb     = 1'b0;
      wb_we      = 1'b0;
      wb_adr     = '0;
      wb_dat_i   = 8'h00;
      oe_model   = '1;
      flag_model = 8'h00;
      for (int i = 0; i < NUM_REGS; i++) reg_model[i] = 8'h00;
      repeat (4) @(posedge clk);
      #1 rst = 1'b1;

      // Reset state
      check_port();
      check_val("flags_out", flags_out, 8'h00);
      for (int a = 0; a < 16; a++) add_read(4'(a));
      run_steps();

      // Data registers and unmapped holes
      for (int i = 0; i < NUM_REGS; i++) add_write(4'(i), 8'($random(seed)));
      for (int a = 7; a < 16; a++) add_write(4'(a), 8'($random(seed)));
      for (int a = 0; a < 16; a++) add_read(4'(a));
      run_steps();

      // Output stage lags the enable write by one cycle
      wb_write(ADDR_OE, 8'h00);
      check_val("port_en", port_en, '0);
      model_write(ADDR_OE, 8'h00);
      @(posedge clk);
      #1 check_port();
      wb_write(ADDR_OE, 8'h04);               // Byte 2 dark again
      model_write(ADDR_OE, 8'h04);
      @(posedge clk);
      #1 check_port();

      // J-K flag commands on both halves
      for (int i = 0; i < 8; i++) begin
         add_write(JK_ADR[i], JK_DAT[i]);
         add_read(JK_ADR[i]);
      end
      run_steps();

      // Same byte as data and as J/K masks
      add_write(4'd0, 8'h96);
      add_write(ADDR_FLAG, 8'h96);
      add_read(4'd0);
      add_read(ADDR_FLAG);
      run_steps();
      check_port();

      $display("** PASS **");
      $finish;
   end

endmodule

// ==== build.f ====
logic/ttl_reg_pkg.sv
logic/reg_bus_if.sv
logic/wb_reg_front.sv
logic/jk_flag_bank.sv
logic/octal_reg_bank.sv
logic/port_driver.sv
logic/ttl_reg_top.sv
verif/ttl_reg_props.sv
verif/ttl_reg_tb.sv

// ==== Bender.yml ====
package:
  name: ttl_reg

sources:
  - logic/ttl_reg_pkg.sv
  - logic/reg_bus_if.sv
  - logic/wb_reg_front.sv
  - logic/jk_flag_bank.sv
  - logic/octal_reg_bank.sv
  - logic/port_driver.sv
  - logic/ttl_reg_top.sv
  - target: simulation
    files:
      - verif/ttl_reg_props.sv
      - verif/ttl_reg_tb.sv
